// ==== common/nts_ts_cfg.svh ====
// ------------------------------------------------
// Fixed NTP header layout, nothing here is meant to be tuned
// Addresses outside 0x10..0x14 read zero
// ------------------------------------------------
`ifndef NTS_TS_CFG_SVH
`define NTS_TS_CFG_SVH

// ------------------------------------------------
// API register map
// ------------------------------------------------
`define NTS_TS_ADDR_W          8
`define NTS_TS_ADDR_CONFIG     8'h10 // LI | VN | Mode | Stratum | Poll | Precision
`define NTS_TS_ADDR_ROOT_DELAY 8'h11
`define NTS_TS_ADDR_ROOT_DISP  8'h12
`define NTS_TS_ADDR_REF_ID     8'h13
`define NTS_TS_ADDR_TX_OFS     8'h14 // Fraction added to tx timestamp

// ------------------------------------------------
// Widths
// ------------------------------------------------
`define NTS_TS_WORD_W 32 // API word and NTP header word
`define NTS_TS_TS_W   64 // Seconds plus fraction
`define NTS_TS_BLK_W  3  // Block index 0..5

// ------------------------------------------------
// Header size
// ------------------------------------------------
`define NTS_TS_HDR_BITS   384
`define NTS_TS_HDR_BLOCKS 6   // 384 / 64

// ------------------------------------------------
// Defaults for zero config fields
// ------------------------------------------------
`define NTS_TS_DEFAULT_MODE    3'd4 // Server
`define NTS_TS_DEFAULT_STRATUM 8'd1 // Primary reference

`endif

// ==== common/nts_ts_api_pkg.sv ====
// ------------------------------------------------
// Types seen by the 32-bit register API
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

package nts_ts_api_pkg;

  // Register address, byte wide
  typedef logic [`NTS_TS_ADDR_W-1:0] api_addr_t;

  // Read and write data word
  typedef logic [`NTS_TS_WORD_W-1:0] api_word_t;

endpackage

`default_nettype wire

// ==== common/nts_ts_hdr_pkg.sv ====
// ------------------------------------------------
// Types of the NTP header side
// Config word layout follows the first NTP header word
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

package nts_ts_hdr_pkg;

  // NTP timestamp
  // Upper half seconds, lower half fraction
  typedef logic [`NTS_TS_TS_W-1:0] ntp_ts_t;

  // Index of a 64-bit header block
  typedef logic [`NTS_TS_BLK_W-1:0] hdr_block_t;

  // ------------------------------------------------
  // Config register
  // ------------------------------------------------
  // API sees a plain word, the transmitter the fields
  typedef union packed {
    logic [`NTS_TS_WORD_W-1:0] word;
    struct packed {
      logic [1:0] li;        // Leap indicator
      logic [2:0] vn;        // Zero means echo client
      logic [2:0] mode;      // Zero means server
      logic [7:0] stratum;   // Zero means 1
      logic [7:0] poll;      // Zero means echo client
      logic [7:0] precision;
    } f;
  } ntp_config_u;

endpackage

`default_nettype wire

// ==== hw/nts_ts_regs.sv ====
// ------------------------------------------------
// Server header registers, write next cycle, read combinational
// Unmapped addresses read zero, writes to them are dropped
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module nts_ts_regs
  import nts_ts_api_pkg::*, nts_ts_hdr_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_areset,

  input  wire logic        i_api_cs,
  input  wire logic        i_api_we,
  input  wire api_addr_t   i_api_address,
  input  wire api_word_t   i_api_write_data,
  output      api_word_t   o_api_read_data,

  output      ntp_config_u o_config,
  output      api_word_t   o_root_delay,
  output      api_word_t   o_root_disp,
  output      api_word_t   o_ref_id,
  output      api_word_t   o_tx_ofs
);

  ntp_config_u config_q;
  api_word_t   root_delay_q;
  api_word_t   root_disp_q;
  api_word_t   ref_id_q;
  api_word_t   tx_ofs_q;

  logic        wr;              // Qualified write
  logic        config_we;
  logic        root_delay_we;
  logic        root_disp_we;
  logic        ref_id_we;
  logic        tx_ofs_we;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign wr            = i_api_cs && i_api_we;
  assign config_we     = wr && (i_api_address == `NTS_TS_ADDR_CONFIG);
  assign root_delay_we = wr && (i_api_address == `NTS_TS_ADDR_ROOT_DELAY);
  assign root_disp_we  = wr && (i_api_address == `NTS_TS_ADDR_ROOT_DISP);
  assign ref_id_we     = wr && (i_api_address == `NTS_TS_ADDR_REF_ID);
  assign tx_ofs_we     = wr && (i_api_address == `NTS_TS_ADDR_TX_OFS);

  // ------------------------------------------------
  // Register update
  // ------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      config_q     <= '0;
      root_delay_q <= '0;
      root_disp_q  <= '0;
      ref_id_q     <= '0;
      tx_ofs_q     <= '0;
    end else begin
      if (config_we)     config_q.word <= i_api_write_data; // Raw word, fields decoded later
      if (root_delay_we) root_delay_q  <= i_api_write_data;
      if (root_disp_we)  root_disp_q   <= i_api_write_data;
      if (ref_id_we)     ref_id_q      <= i_api_write_data;
      if (tx_ofs_we)     tx_ofs_q      <= i_api_write_data;
    end
  end

  // ------------------------------------------------
  // Read mux
  // ------------------------------------------------
  always_comb begin
    o_api_read_data = '0;         // Unmapped reads zero
    if (i_api_cs && !i_api_we) begin
      case (i_api_address)
        `NTS_TS_ADDR_CONFIG:     o_api_read_data = config_q.word;
        `NTS_TS_ADDR_ROOT_DELAY: o_api_read_data = root_delay_q;
        `NTS_TS_ADDR_ROOT_DISP:  o_api_read_data = root_disp_q;
        `NTS_TS_ADDR_REF_ID:     o_api_read_data = ref_id_q;
        `NTS_TS_ADDR_TX_OFS:     o_api_read_data = tx_ofs_q;
        default:                 o_api_read_data = '0;
      endcase
    end
  end

  // Values to header builder and capture
  assign o_config     = config_q;
  assign o_root_delay = root_delay_q;
  assign o_root_disp  = root_disp_q;
  assign o_ref_id     = ref_id_q;
  assign o_tx_ofs     = tx_ofs_q;

endmodule

`default_nettype wire

// ==== hw/nts_ts_capture.sv ====
// ------------------------------------------------
// Request capture, loads one cycle after the strobe
// Tx offset counts in fraction units and carries into seconds
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module nts_ts_capture
  import nts_ts_api_pkg::*, nts_ts_hdr_pkg::*;
(
  input  wire logic                      i_clk,
  input  wire logic                      i_areset,

  input  wire ntp_ts_t                   i_ntp_time,

  // From transmitter
  input  wire logic                      i_load,      // Transmit accepted
  input  wire logic                      i_idle,

  // From parser
  input  wire logic                      i_record_rx,
  input  wire ntp_ts_t                   i_origin_ts,
  input  wire logic [2:0]                i_version,
  input  wire logic [7:0]                i_poll,

  // From register bank
  input  wire api_word_t                 i_tx_ofs,

  output      ntp_ts_t                   o_origin_ts,
  output      ntp_ts_t                   o_rx_ts,
  output      ntp_ts_t                   o_tx_ts,
  output      logic [`NTS_TS_WORD_W-1:0] o_ref_seconds,
  output      logic [2:0]                o_version,
  output      logic [7:0]                o_poll
);

  ntp_ts_t                   origin_ts_q;
  ntp_ts_t                   rx_ts_q;
  ntp_ts_t                   tx_ts_q;
  logic [`NTS_TS_WORD_W-1:0] ref_seconds_q;
  logic [2:0]                version_q;
  logic [7:0]                poll_q;

  ntp_ts_t                   tx_ts_next;   // Now plus offset
  logic [`NTS_TS_WORD_W-1:0] now_seconds;

  assign now_seconds = i_ntp_time[`NTS_TS_TS_W-1 -: `NTS_TS_WORD_W];

  // Offset lands in fraction half
  assign tx_ts_next = i_ntp_time + {{(`NTS_TS_TS_W - `NTS_TS_WORD_W){1'b0}}, i_tx_ofs};

  // ------------------------------------------------
  // Receive timestamp
  // ------------------------------------------------
  // Frozen while a reply is being served
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      rx_ts_q <= '0;
    end else if (i_idle && i_record_rx) begin
      rx_ts_q <= i_ntp_time;
    end
  end

  // ------------------------------------------------
  // Transmit time fields
  // ------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      origin_ts_q   <= '0;
      tx_ts_q       <= '0;
      ref_seconds_q <= '0;
      version_q     <= '0;
      poll_q        <= '0;
    end else if (i_load) begin
      origin_ts_q   <= i_origin_ts;          // Echoed back to client
      tx_ts_q       <= tx_ts_next;
      ref_seconds_q <= now_seconds - 1'b1;   // Assume last sync at previous second
      version_q     <= i_version;
      poll_q        <= i_poll;
    end
  end

  assign o_origin_ts   = origin_ts_q;
  assign o_rx_ts       = rx_ts_q;
  assign o_tx_ts       = tx_ts_q;
  assign o_ref_seconds = ref_seconds_q;
  assign o_version     = version_q;
  assign o_poll        = poll_q;

endmodule

`default_nettype wire

// ==== header_tx/nts_ts_header_tx.sv ====
// ------------------------------------------------
// NTP reply header served as six 64-bit blocks, MSB first
// Data is combinational from registers and index, no FIFO behind it
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module nts_ts_header_tx
  import nts_ts_api_pkg::*, nts_ts_hdr_pkg::*;
(
  input  wire logic                      i_clk,
  input  wire logic                      i_areset,

  input  wire logic                      i_parser_transmit,
  input  wire logic                      i_parser_clear,     // Aborts a reply
  input  wire logic                      i_tx_read,

  // Register values
  input  wire ntp_config_u               i_config,
  input  wire api_word_t                 i_root_delay,
  input  wire api_word_t                 i_root_disp,
  input  wire api_word_t                 i_ref_id,

  // Captured fields
  input  wire ntp_ts_t                   i_origin_ts,
  input  wire ntp_ts_t                   i_rx_ts,
  input  wire ntp_ts_t                   i_tx_ts,
  input  wire logic [`NTS_TS_WORD_W-1:0] i_ref_seconds,
  input  wire logic [2:0]                i_version,
  input  wire logic [7:0]                i_poll,

  output      logic                      o_load,
  output      logic                      o_idle,
  output      logic                      o_tx_empty,
  output      hdr_block_t                o_tx_block,
  output      logic [`NTS_TS_TS_W-1:0]   o_tx_data
);

  localparam hdr_block_t LAST_BLOCK = hdr_block_t'(`NTS_TS_HDR_BLOCKS - 1);

  logic                         tx_active_q;   // 0 idle, 1 serving blocks
  hdr_block_t                   block_q;
  ntp_config_u                  hdr_word0;     // First header word after defaults
  ntp_ts_t                      ref_ts;
  logic [`NTS_TS_HDR_BITS-1:0]  hdr;

  // ------------------------------------------------
  // Transmit state and block counter
  // ------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      tx_active_q <= 1'b0;
      block_q     <= '0;
    end else if (i_parser_clear) begin
      tx_active_q <= 1'b0;               // Clear wins over everything
      block_q     <= '0;
    end else if (!tx_active_q) begin
      block_q <= '0;
      if (i_parser_transmit) tx_active_q <= 1'b1;
    end else if (i_tx_read) begin
      if (block_q == LAST_BLOCK) begin
        tx_active_q <= 1'b0;             // Last block consumed
        block_q     <= '0;
      end else begin
        block_q <= block_q + 1'b1;
      end
    end
  end

  assign o_idle     = !tx_active_q;
  assign o_load     = i_parser_transmit && !tx_active_q; // Strobe while busy is dropped
  assign o_tx_empty = !tx_active_q;
  assign o_tx_block = block_q;

  // ------------------------------------------------
  // Defaults for zero config fields
  // ------------------------------------------------
  always_comb begin
    hdr_word0           = i_config;      // LI and precision pass as written
    if (i_config.f.vn == '0)      hdr_word0.f.vn      = i_version;
    if (i_config.f.mode == '0)    hdr_word0.f.mode    = `NTS_TS_DEFAULT_MODE;
    if (i_config.f.stratum == '0) hdr_word0.f.stratum = `NTS_TS_DEFAULT_STRATUM;
    if (i_config.f.poll == '0)    hdr_word0.f.poll    = i_poll;
  end

  // Reference time has zero fraction
  assign ref_ts = {i_ref_seconds, {(`NTS_TS_TS_W - `NTS_TS_WORD_W){1'b0}}};

  // ------------------------------------------------
  // Header assembly and block mux
  // ------------------------------------------------
  assign hdr = {hdr_word0.word,
                i_root_delay,
                i_root_disp,
                i_ref_id,
                ref_ts,
                i_origin_ts,
                i_rx_ts,
                i_tx_ts};

  // Block 0 is the top 64 bits
  always_comb begin
    o_tx_data = '0;
    if (block_q <= LAST_BLOCK) begin
      o_tx_data = hdr[(int'(LAST_BLOCK) - int'(block_q)) * `NTS_TS_TS_W +: `NTS_TS_TS_W];
    end
  end

endmodule

`default_nettype wire

// ==== hw/nts_timestamp.sv ====
// ------------------------------------------------
// NTP server timestamp block, wiring only
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module nts_timestamp
  import nts_ts_api_pkg::*, nts_ts_hdr_pkg::*;
(
  input  wire logic                     i_clk,
  input  wire logic                     i_areset,   // Async, active high

  input  wire ntp_ts_t                  i_ntp_time,

  // Parser side
  input  wire logic                     i_parser_transmit,
  input  wire logic                     i_parser_record_receive_timestamp,
  input  wire logic                     i_parser_clear,
  input  wire ntp_ts_t                  i_parser_origin_timestamp,
  input  wire logic [2:0]               i_parser_version_number,
  input  wire logic [7:0]               i_parser_poll,

  // Header consumer
  input  wire logic                     i_tx_read,
  output      logic                     o_tx_empty,
  output      hdr_block_t               o_tx_ntp_header_block,
  output      logic [`NTS_TS_TS_W-1:0]  o_tx_ntp_header_data,

  // API
  input  wire logic                     i_api_cs,
  input  wire logic                     i_api_we,
  input  wire api_addr_t                i_api_address,
  input  wire api_word_t                i_api_write_data,
  output      api_word_t                o_api_read_data
);

  // Register values
  ntp_config_u config_word;
  api_word_t   root_delay;
  api_word_t   root_disp;
  api_word_t   ref_id;
  api_word_t   tx_ofs;

  // Transmitter control to capture
  logic        load;
  logic        idle;

  // Captured request fields
  ntp_ts_t                   origin_ts;
  ntp_ts_t                   rx_ts;
  ntp_ts_t                   tx_ts;
  logic [`NTS_TS_WORD_W-1:0] ref_seconds;
  logic [2:0]                version;
  logic [7:0]                poll;

  nts_ts_regs regs_i (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_api_read_data  (o_api_read_data),
    .o_config         (config_word),
    .o_root_delay     (root_delay),
    .o_root_disp      (root_disp),
    .o_ref_id         (ref_id),
    .o_tx_ofs         (tx_ofs)
  );

  nts_ts_capture capture_i (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_ntp_time    (i_ntp_time),
    .i_load        (load),
    .i_idle        (idle),
    .i_record_rx   (i_parser_record_receive_timestamp),
    .i_origin_ts   (i_parser_origin_timestamp),
    .i_version     (i_parser_version_number),
    .i_poll        (i_parser_poll),
    .i_tx_ofs      (tx_ofs),
    .o_origin_ts   (origin_ts),
    .o_rx_ts       (rx_ts),
    .o_tx_ts       (tx_ts),
    .o_ref_seconds (ref_seconds),
    .o_version     (version),
    .o_poll        (poll)
  );

  nts_ts_header_tx header_tx_i (
    .i_clk             (i_clk),
    .i_areset          (i_areset),
    .i_parser_transmit (i_parser_transmit),
    .i_parser_clear    (i_parser_clear),
    .i_tx_read         (i_tx_read),
    .i_config          (config_word),
    .i_root_delay      (root_delay),
    .i_root_disp       (root_disp),
    .i_ref_id          (ref_id),
    .i_origin_ts       (origin_ts),
    .i_rx_ts           (rx_ts),
    .i_tx_ts           (tx_ts),
    .i_ref_seconds     (ref_seconds),
    .i_version         (version),
    .i_poll            (poll),
    .o_load            (load),
    .o_idle            (idle),
    .o_tx_empty        (o_tx_empty),
    .o_tx_block        (o_tx_ntp_header_block),
    .o_tx_data         (o_tx_ntp_header_data)
  );

endmodule

`default_nettype wire

// ==== verif/nts_timestamp_assert.sv ====
// ------------------------------------------------
// Header port protocol checks, bound to the top level
// Data hold check assumes no API writes during a reply
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module nts_timestamp_assert
  import nts_ts_hdr_pkg::*;
(
  input wire logic                    i_clk,
  input wire logic                    i_areset,
  input wire logic                    i_transmit,
  input wire logic                    i_clear,
  input wire logic                    i_tx_read,
  input wire logic                    i_tx_empty,
  input wire hdr_block_t              i_block,
  input wire logic [`NTS_TS_TS_W-1:0] i_data
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam hdr_block_t LAST_BLOCK = hdr_block_t'(`NTS_TS_HDR_BLOCKS - 1);

  int unsigned fail_count = 0;   // Summed up by the testbench

  // ------------------------------------------------
  // Block index range
  // ------------------------------------------------
  a_idle_index: assert property (@(posedge i_clk) disable iff (i_areset)
    i_tx_empty |-> (i_block == '0))
    else begin $error("block index not zero while empty"); fail_count++; end

  a_index_range: assert property (@(posedge i_clk) disable iff (i_areset)
    i_block <= LAST_BLOCK)
    else begin $error("block index beyond last block"); fail_count++; end

  // ------------------------------------------------
  // State changes
  // ------------------------------------------------
  a_start: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_transmit && i_tx_empty && !i_clear) |=> !i_tx_empty)
    else begin $error("transmit while empty did not start a reply"); fail_count++; end

  a_last_read: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_tx_read && !i_tx_empty && !i_clear && (i_block == LAST_BLOCK)) |=> i_tx_empty)
    else begin $error("read of last block did not end the reply"); fail_count++; end

  a_clear: assert property (@(posedge i_clk) disable iff (i_areset)
    i_clear |=> i_tx_empty)
    else begin $error("clear did not return to empty"); fail_count++; end

  // Back-pressure, no read means nothing moves
  a_hold: assert property (@(posedge i_clk) disable iff (i_areset)
    (!i_tx_empty && !i_tx_read && !i_clear) |=> ($stable(i_data) && $stable(i_block)))
    else begin $error("block data moved without a read"); fail_count++; end

endmodule

bind nts_timestamp nts_timestamp_assert assert_i (
  .i_clk      (i_clk),
  .i_areset   (i_areset),
  .i_transmit (i_parser_transmit),
  .i_clear    (i_parser_clear),
  .i_tx_read  (i_tx_read),
  .i_tx_empty (o_tx_empty),
  .i_block    (o_tx_ntp_header_block),
  .i_data     (o_tx_ntp_header_data)
);

`default_nettype wire

// ==== verif/tb_nts_timestamp.sv ====
// ------------------------------------------------
// Testbench, header model built from the NTP field rules
// No API writes while a reply is being read
// ------------------------------------------------
`default_nettype none

`include "nts_ts_cfg.svh"

module tb_nts_timestamp
  import nts_ts_api_pkg::*, nts_ts_hdr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 2000;   // Six tests of about 60 cycles, wide margin
  localparam int TOP = `NTS_TS_HDR_BITS - 1;

  logic       i_clk;
  logic       i_areset;
  ntp_ts_t    i_ntp_time;
  logic       i_parser_transmit;
  logic       i_parser_record_receive_timestamp;
  logic       i_parser_clear;
  ntp_ts_t    i_parser_origin_timestamp;
  logic [2:0] i_parser_version_number;
  logic [7:0] i_parser_poll;
  logic       i_tx_read;
  logic       o_tx_empty;
  hdr_block_t o_tx_ntp_header_block;
  logic [`NTS_TS_TS_W-1:0] o_tx_ntp_header_data;
  logic       i_api_cs;
  logic       i_api_we;
  api_addr_t  i_api_address;
  api_word_t  i_api_write_data;
  api_word_t  o_api_read_data;

  int        errors = 0;
  int        checks = 0;
  int        test_errors = 0;
  int        cycles = 0;
  logic [`NTS_TS_HDR_BITS-1:0] exp_hdr;      // Expected reply header
  api_word_t cfg, delay, disp, refid, ofs;   // Register mirror
  ntp_ts_t   rx_time;                        // Last recorded receive time

  nts_timestamp nts_timestamp_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = !i_clk;
  end

  // Run limit
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------
  // Model and checks
  // ------------------------------------------------
  function automatic logic [`NTS_TS_HDR_BITS-1:0] expected_header(
    input ntp_ts_t now, input ntp_ts_t origin, input logic [2:0] ver, input logic [7:0] poll);
    logic [31:0] w0;
    w0 = cfg;
    if (cfg[29:27] == 3'd0) w0[29:27] = ver;     // VN echoes client
    if (cfg[26:24] == 3'd0) w0[26:24] = 3'd4;    // Server mode
    if (cfg[23:16] == 8'd0) w0[23:16] = 8'd1;    // Stratum 1
    if (cfg[15:8] == 8'd0)  w0[15:8]  = poll;    // Poll echoes client
    return {w0, delay, disp, refid, now[63:32] - 32'd1, 32'd0, origin, rx_time,
            now + {32'd0, ofs}};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // ------------------------------------------------
  // Bus and parser drivers
  // ------------------------------------------------
  task automatic api_write(input api_addr_t addr, input api_word_t data);
    @(posedge i_clk);
    i_api_cs <= 1'b1;
    i_api_we <= 1'b1;
    i_api_address <= addr;
    i_api_write_data <= data;
    @(posedge i_clk);
    i_api_cs <= 1'b0;
    i_api_we <= 1'b0;
  endtask

  task automatic api_read_check(input string name, input api_addr_t addr, input api_word_t exp);
    @(posedge i_clk);
    i_api_cs <= 1'b1;
    i_api_address <= addr;
    @(negedge i_clk);                  // Combinational read settled
    check(name, exp, o_api_read_data);
    @(posedge i_clk);
    i_api_cs <= 1'b0;
  endtask

  task automatic write_all(input api_word_t config_value);
    cfg   = config_value;
    delay = $urandom;
    disp  = $urandom;
    refid = $urandom;
    ofs   = $urandom;
    api_write(`NTS_TS_ADDR_CONFIG, cfg);
    api_write(`NTS_TS_ADDR_ROOT_DELAY, delay);
    api_write(`NTS_TS_ADDR_ROOT_DISP, disp);
    api_write(`NTS_TS_ADDR_REF_ID, refid);
    api_write(`NTS_TS_ADDR_TX_OFS, ofs);
  endtask

  task automatic record_rx();
    @(posedge i_clk);
    rx_time = {$urandom, $urandom};
    i_ntp_time <= rx_time;
    i_parser_record_receive_timestamp <= 1'b1;
    @(posedge i_clk);
    i_parser_record_receive_timestamp <= 1'b0;
  endtask

  // Transmit strobe, then wait for the reply to open
  task automatic start_reply();
    ntp_ts_t    now;
    ntp_ts_t    origin;
    logic [2:0] ver;
    logic [7:0] poll;
    now    = {$urandom, $urandom};
    origin = {$urandom, $urandom};
    ver    = 3'($urandom_range(1, 4));
    poll   = 8'($urandom_range(4, 17));
    @(posedge i_clk);
    i_ntp_time <= now;
    i_parser_origin_timestamp <= origin;
    i_parser_version_number <= ver;
    i_parser_poll <= poll;
    i_parser_transmit <= 1'b1;
    @(posedge i_clk);
    i_parser_transmit <= 1'b0;
    @(negedge i_clk);
    while (o_tx_empty) @(negedge i_clk);
    exp_hdr = expected_header(now, origin, ver, poll);
  endtask

  // Read pulses with random gaps, data must hold in the gaps
  task automatic read_blocks(input string name, input int first, input int last);
    int gap;
    for (int k = first; k <= last; k++) begin
      @(negedge i_clk);
      check(name, 64'(k), 64'(o_tx_ntp_header_block));
      check(name, exp_hdr[TOP - 64*k -: 64], o_tx_ntp_header_data);
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(negedge i_clk);
        check(name, exp_hdr[TOP - 64*k -: 64], o_tx_ntp_header_data);
      end
      @(posedge i_clk);
      i_tx_read <= 1'b1;
      @(posedge i_clk);
      i_tx_read <= 1'b0;
    end
  endtask

  initial begin
    void'($urandom(68004));
    i_areset = 1'b1;
    i_ntp_time = '0;
    i_parser_transmit = 1'b0;
    i_parser_record_receive_timestamp = 1'b0;
    i_parser_clear = 1'b0;
    i_parser_origin_timestamp = '0;
    i_parser_version_number = '0;
    i_parser_poll = '0;
    i_tx_read = 1'b0;
    i_api_cs = 1'b0;
    i_api_we = 1'b0;
    i_api_address = '0;
    i_api_write_data = '0;
    repeat (10) @(posedge i_clk);
    i_areset <= 1'b0;

    // Reset state
    @(negedge i_clk);
    check("reset", 64'd1, 64'(o_tx_empty));
    check("reset", 64'd0, 64'(o_tx_ntp_header_block));
    for (int a = 8'h10; a <= 8'h14; a++) api_read_check("reset", api_addr_t'(a), '0);
    finish_test("reset");

    // Register readback, every config field nonzero
    write_all($urandom | 32'h0901_0100);
    api_read_check("regs", `NTS_TS_ADDR_CONFIG, cfg);
    api_read_check("regs", `NTS_TS_ADDR_ROOT_DELAY, delay);
    api_read_check("regs", `NTS_TS_ADDR_ROOT_DISP, disp);
    api_read_check("regs", `NTS_TS_ADDR_REF_ID, refid);
    api_read_check("regs", `NTS_TS_ADDR_TX_OFS, ofs);
    api_read_check("regs", 8'h00, '0);
    api_read_check("regs", 8'h02, '0);
    finish_test("regs");

    // Full reply with back-pressure
    record_rx();
    start_reply();
    read_blocks("reply", 0, 5);
    @(negedge i_clk);
    check("reply", 64'd1, 64'(o_tx_empty));
    finish_test("reply");

    // Zero config, defaults fill the first word
    write_all('0);
    record_rx();
    start_reply();
    read_blocks("defaults", 0, 5);
    finish_test("defaults");

    // Stray strobes in the middle of a reply
    write_all($urandom | 32'h0901_0100);
    record_rx();
    start_reply();
    read_blocks("busy", 0, 1);
    @(posedge i_clk);
    i_ntp_time <= {$urandom, $urandom};
    i_parser_origin_timestamp <= {$urandom, $urandom};
    i_parser_transmit <= 1'b1;
    i_parser_record_receive_timestamp <= 1'b1;
    @(posedge i_clk);
    i_parser_transmit <= 1'b0;
    i_parser_record_receive_timestamp <= 1'b0;
    read_blocks("busy", 2, 5);
    finish_test("busy");

    // Abort, then a fresh reply
    record_rx();
    start_reply();
    read_blocks("clear", 0, 2);
    @(posedge i_clk);
    i_parser_clear <= 1'b1;
    @(posedge i_clk);
    i_parser_clear <= 1'b0;
    @(negedge i_clk);
    check("clear", 64'd1, 64'(o_tx_empty));
    check("clear", 64'd0, 64'(o_tx_ntp_header_block));
    record_rx();
    start_reply();
    read_blocks("clear", 0, 5);
    finish_test("clear");

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             nts_timestamp_i.assert_i.fail_count);
    if (errors == 0 && nts_timestamp_i.assert_i.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/nts_ts_api_pkg.sv
common/nts_ts_hdr_pkg.sv
hw/nts_ts_regs.sv
hw/nts_ts_capture.sv
header_tx/nts_ts_header_tx.sv
hw/nts_timestamp.sv
verif/nts_timestamp_assert.sv
verif/tb_nts_timestamp.sv
